//--- Makefile
TOP = simd_alu_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "*** FAILED ***" >> $(LOG)
	cat $(LOG)
	! grep -q '\*\*\* FAILED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/simd_alu_sva.sv
`timescale 1ns/10ps

module simd_alu_sva (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    valid_i,
  input simd_alu_pkg::alu_req_t  req_i,
  input logic                    valid_out_i,
  input simd_alu_pkg::alu_resp_t resp_out_i
);

  import simd_alu_pkg::*;

  logic sat_op;

  assign sat_op = req_i.op inside {VSADDU, VSADD, VSSUBU, VSSUB};

  // All bytes of one element carry the same flag
  function automatic logic sat_uniform(input vxsat_t sat, input vew_e vew);
    int unsigned g;
    logic        ok;

    g  = 1 << vew;
    ok = 1'b1;
    for (int k = 0; k < 8; k++) begin
      if (sat[k] != sat[k - (k % g)]) ok = 1'b0;
    end
    return ok;
  endfunction

  a_reset_clears_valid: assert property (@(posedge clk_i) reset_i |=> !valid_out_i)
    else $error("valid_o high in the cycle after reset");

  a_valid_follows: assert property (@(posedge clk_i) !reset_i |=> valid_out_i == $past(valid_i))
    else $error("valid_o does not follow valid_i by one cycle");

  a_no_sat_flags: assert property (@(posedge clk_i) disable iff (reset_i)
    !sat_op |=> resp_out_i.vxsat == '0)
    else $error("vxsat set for a non-saturating operation");

  a_sat_per_element: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_out_i |-> sat_uniform(resp_out_i.vxsat, $past(req_i.vew)))
    else $error("vxsat bytes differ within one element");

endmodule

bind simd_alu simd_alu_sva u_sva (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .valid_i     (valid_i),
  .req_i       (req_i),
  .valid_out_i (valid_o),
  .resp_out_i  (resp_o)
);

//--- bench/simd_alu_tb.sv
`timescale 1ns/10ps

module simd_alu_tb;

  import simd_alu_pkg::*;

  localparam int num_req = 144 + 400 + 96 + 192 + 224 + 224;

  typedef struct packed {
    logic      valid;
    alu_req_t  req;
    alu_resp_t resp;
  } expect_t;

  logic      clk;
  logic      reset;
  logic      req_valid;
  alu_req_t  req;
  logic      resp_valid;
  alu_resp_t resp;

  expect_t   exp_q[$];
  int        value_errors = 0;
  int        other_errors = 0;

  simd_alu dut (
    .clk_i   (clk),
    .reset_i (reset),
    .valid_i (req_valid),
    .req_i   (req),
    .valid_o (resp_valid),
    .resp_o  (resp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic alu_resp_t ref_alu(input alu_req_t rq);
    int unsigned        w;
    int unsigned        amt;
    logic [63:0]        mask;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        r;
    logic signed [65:0] sa;
    logic signed [65:0] sb;
    logic signed [65:0] t;
    logic signed [65:0] hi;
    logic signed [65:0] lo;
    logic               sgn;
    logic               sat;
    logic               rb;
    logic               less;
    logic               eq;
    alu_resp_t          rsp;

    w    = 8 << rq.vew;
    mask = 64'hFFFF_FFFF_FFFF_FFFF >> (64 - w);
    hi   = $signed({3'b000, mask[63:1]});
    lo   = -hi - 66'sd1;
    sgn  = rq.op inside {VSADD, VSSUB, VAADD, VSRA, VMIN, VMAX, VMSLT, VMSLE, VMSGT};
    rsp  = '0;
    for (int e = 0; e < 64 / w; e++) begin
      ua  = (rq.operand_a >> (e * w)) & mask;
      ub  = (rq.operand_b >> (e * w)) & mask;
      sa  = $signed({2'b00, ua});
      sb  = $signed({2'b00, ub});
      if (sgn && ua[w-1]) sa = sa - (66'sd1 <<< w);
      if (sgn && ub[w-1]) sb = sb - (66'sd1 <<< w);
      amt  = 32'(ua[5:0]) % w;
      less = sb < sa;
      eq   = ua == ub;
      sat  = 1'b0;
      case (rq.op)
        VAND:   r = ua & ub;
        VOR:    r = ua | ub;
        VXOR:   r = ua ^ ub;
        VADD:   r = ua + ub;
        VSUB:   r = ub - ua;
        VRSUB:  r = ua - ub;
        VSADDU: begin
          t   = sa + sb;
          sat = t > $signed({2'b00, mask});
          r   = sat ? mask : t[63:0];
        end
        VSSUBU: begin
          t   = sb - sa;
          sat = t < 66'sd0;
          r   = sat ? '0 : t[63:0];
        end
        VSADD, VSSUB: begin
          t   = (rq.op == VSADD) ? sa + sb : sb - sa;
          sat = (t > hi) || (t < lo);
          r   = (t > hi) ? hi[63:0] : (t < lo) ? lo[63:0] : t[63:0];
        end
        VAADDU, VAADD: begin
          t = sa + sb;
          case (rq.vxrm)
            RNU:     rb = t[0];
            RNE:     rb = t[1] & t[0];
            RDN:     rb = 1'b0;
            default: rb = ~t[1] & t[0];
          endcase
          t = (t >>> 1) + $signed({65'd0, rb});
          r = t[63:0];
        end
        VSLL:   r = ub << amt;
        VSRL:   r = ub >> amt;
        VSRA: begin
          t = sb >>> amt;
          r = t[63:0];
        end
        VMINU, VMIN:   r = less ? ub : ua;
        VMAXU, VMAX:   r = less ? ua : ub;
        VMSEQ:         r = {63'd0, eq};
        VMSNE:         r = {63'd0, !eq};
        VMSLTU, VMSLT: r = {63'd0, less};
        VMSLEU, VMSLE: r = {63'd0, less | eq};
        VMSGTU, VMSGT: r = {63'd0, !(less | eq)};
        default:       r = '0;
      endcase
      rsp.result = rsp.result | ((r & mask) << (e * w));
      for (int k = 0; k < w / 8; k++) begin
        rsp.vxsat[e * (w / 8) + k] = sat;
      end
    end
    return rsp;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Limits mode mixes 0, 1, signed max/min, all ones and random per element
  function automatic logic [63:0] pick_word(input int unsigned w, input bit limits);
    logic [63:0] word;
    logic [63:0] mask;
    logic [63:0] v;

    word = '0;
    mask = 64'hFFFF_FFFF_FFFF_FFFF >> (64 - w);
    for (int e = 0; e < 64 / w; e++) begin
      v = {$urandom, $urandom};
      if (limits) begin
        case ($urandom_range(0, 5))
          0: v = '0;
          1: v = 64'd1;
          2: v = mask >> 1;
          3: v = ~(mask >> 1);
          4: v = mask;
          default: v = v;
        endcase
      end
      word = word | ((v & mask) << (e * w));
    end
    return word;
  endfunction

  function automatic logic [63:0] fill(input logic [63:0] v, input int unsigned w);
    logic [63:0] word;

    word = '0;
    for (int e = 0; e < 64 / w; e++) begin
      word = word | (v << (e * w));
    end
    return word;
  endfunction

  task automatic send(input alu_op_e op, input vew_e vew, input vxrm_e rm,
                      input logic [63:0] a, input logic [63:0] b);
    alu_req_t rq;

    rq = '{op: op, vew: vew, vxrm: rm, operand_a: a, operand_b: b};
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= rq;
    exp_q.push_back('{valid: 1'b1, req: rq, resp: ref_alu(rq)});
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      req_valid <= 1'b0;
      req       <= '0;
      exp_q.push_back('0);
    end
  endtask

  task automatic sweep(input alu_op_e op, input vxrm_e rm, input int count, input bit limits);
    int unsigned w;

    for (int v = 0; v < 4; v++) begin
      w = 8 << v;
      for (int n = 0; n < count; n++) begin
        send(op, vew_e'(v), rm, pick_word(w, limits), pick_word(w, limits));
      end
    end
  endtask

  // Every pair of limit values, same value in all elements
  task automatic sat_corners(input alu_op_e op);
    int unsigned w;
    logic [63:0] mask;
    logic [63:0] vals[5];

    for (int v = 0; v < 4; v++) begin
      w    = 8 << v;
      mask = 64'hFFFF_FFFF_FFFF_FFFF >> (64 - w);
      vals = '{64'd0, 64'd1, mask >> 1, (mask >> 1) + 64'd1, mask};
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          send(op, vew_e'(v), RNU, fill(vals[i], w), fill(vals[j], w));
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checker, one cycle behind the driver
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    expect_t want;
    alu_op_e op;

    if (exp_q.size() > 1) begin
      want = exp_q.pop_front();
      op   = want.req.op;
      if (resp_valid !== want.valid) begin
        value_errors++;
        $display("Fail at %0t: valid_o is %b, expected %b", $time, resp_valid, want.valid);
      end else if (resp !== want.resp) begin
        value_errors++;
        $display("Fail at %0t: %s ew%0d a=%h b=%h gave %h/%h, expected %h/%h", $time,
                 op.name(), 8 << want.req.vew, want.req.operand_a, want.req.operand_b,
                 resp.result, resp.vxsat, want.resp.result, want.resp.vxsat);
      end
    end else if (resp_valid !== 1'b0) begin
      other_errors++;
      $display("valid_o went high at %0t with no request outstanding", $time);
    end
  end

  initial begin
    #((num_req + 20) * 40);
    $display("Timeout: the run did not finish within %0d clock cycles", num_req + 20);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(25));
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    idle(3);

    for (int o = VAND; o <= VRSUB; o++) sweep(alu_op_e'(o), RNU, 6, 1'b0);
    idle(1);
    for (int o = VSADDU; o <= VSSUB; o++) begin
      sat_corners(alu_op_e'(o));
      sweep(alu_op_e'(o), RNU, 6, 1'b1);
    end
    idle(1);
    for (int m = 0; m < 4; m++) begin
      sweep(VAADDU, vxrm_e'(m), 6, 1'b1);
      sweep(VAADD, vxrm_e'(m), 6, 1'b1);
    end
    idle(1);
    // Random shift amounts reach past the element width
    for (int o = VSLL; o <= VMAX; o++) sweep(alu_op_e'(o), RNU, 8, o >= VMINU);
    idle(1);
    for (int o = VMSEQ; o <= VMSGT; o++) begin
      sweep(alu_op_e'(o), RNU, 6, 1'b1);
      for (int v = 0; v < 4; v++) begin
        logic [63:0] a;
        a = pick_word(8 << v, 1'b1);
        send(alu_op_e'(o), vew_e'(v), RNU, a, a);
      end
    end
    idle(2);

    repeat (2) @(negedge clk);
    @(posedge clk);
    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- list.f
source/simd_alu_pkg.sv
source/simd_arith_unit.sv
source/simd_compare_unit.sv
source/simd_shift_unit.sv
source/simd_alu.sv
bench/simd_alu_sva.sv
bench/simd_alu_tb.sv

//--- source/simd_alu.sv
`timescale 1ns/10ps

module simd_alu (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    valid_i,
  input  simd_alu_pkg::alu_req_t  req_i,
  output logic                    valid_o,
  output simd_alu_pkg::alu_resp_t resp_o
);

  import simd_alu_pkg::*;

  lane_word_u opa;
  lane_word_u opb;
  lane_word_u logic_res;
  lane_word_u arith_res;
  lane_word_u cmp_res;
  lane_word_u shift_res;
  vxsat_t     arith_sat;

  logic       is_logic;
  logic       is_arith;
  logic       is_shift;
  logic       is_sat;

  alu_resp_t  resp_d;
  alu_resp_t  resp_q;
  logic       valid_q;

  assign opa = req_i.operand_a;
  assign opb = req_i.operand_b;

  ////////////////////////////////////////////////////////////
  // Operation class
  ////////////////////////////////////////////////////////////

  assign is_logic = req_i.op inside {VAND, VOR, VXOR};
  assign is_arith = req_i.op inside {VADD, VSUB, VRSUB, VSADDU, VSADD,
                                     VSSUBU, VSSUB, VAADDU, VAADD};
  assign is_shift = req_i.op inside {VSLL, VSRL, VSRA};
  assign is_sat   = req_i.op inside {VSADDU, VSADD, VSSUBU, VSSUB};

  // Bitwise ops need no lane split
  always_comb begin
    unique case (req_i.op)
      VAND:    logic_res = opa & opb;
      VOR:     logic_res = opa | opb;
      VXOR:    logic_res = opa ^ opb;
      default: logic_res = '0;
    endcase
  end

  simd_arith_unit u_arith (
    .op_i     (req_i.op),
    .vew_i    (req_i.vew),
    .vxrm_i   (req_i.vxrm),
    .opa_i    (opa),
    .opb_i    (opb),
    .result_o (arith_res),
    .vxsat_o  (arith_sat)
  );

  simd_compare_unit u_compare (
    .op_i     (req_i.op),
    .vew_i    (req_i.vew),
    .opa_i    (opa),
    .opb_i    (opb),
    .result_o (cmp_res)
  );

  simd_shift_unit u_shift (
    .op_i     (req_i.op),
    .vew_i    (req_i.vew),
    .opa_i    (opa),
    .opb_i    (opb),
    .result_o (shift_res)
  );

  ////////////////////////////////////////////////////////////
  // Result select and output stage
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (is_logic) begin
      resp_d.result = logic_res;
    end else if (is_arith) begin
      resp_d.result = arith_res;
    end else if (is_shift) begin
      resp_d.result = shift_res;
    end else begin
      resp_d.result = cmp_res;
    end
    resp_d.vxsat = is_sat ? arith_sat : '0;
  end

  // Idle cycles load zero so the response is clean when not valid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      resp_q  <= '0;
    end else begin
      valid_q <= valid_i;
      resp_q  <= valid_i ? resp_d : '0;
    end
  end

  assign valid_o = valid_q;
  assign resp_o  = resp_q;

endmodule

//--- source/simd_alu_pkg.sv
package simd_alu_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  localparam int unsigned data_width = 64;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    VAND,
    VOR,
    VXOR,
    VADD,
    VSUB,
    VRSUB,
    VSADDU,
    VSADD,
    VSSUBU,
    VSSUB,
    VAADDU,
    VAADD,
    VSLL,
    VSRL,
    VSRA,
    VMINU,
    VMIN,
    VMAXU,
    VMAX,
    VMSEQ,
    VMSNE,
    VMSLTU,
    VMSLT,
    VMSLEU,
    VMSLE,
    VMSGTU,
    VMSGT
  } alu_op_e;

  // Element width of one operation
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Fixed-point rounding for the averaging add
  typedef enum logic [1:0] {
    RNU,
    RNE,
    RDN,
    ROD
  } vxrm_e;

  // One datapath word seen as lanes of each element width
  typedef union packed {
    logic [data_width/64-1:0][63:0] w64;
    logic [data_width/32-1:0][31:0] w32;
    logic [data_width/16-1:0][15:0] w16;
    logic [data_width/8-1:0][7:0]   w8;
  } lane_word_u;

  // One flag per byte, all bytes of a clamped element set
  typedef logic [data_width/8-1:0] vxsat_t;

  typedef struct packed {
    alu_op_e                 op;
    vew_e                    vew;
    vxrm_e                   vxrm;
    logic [data_width-1:0]   operand_a;
    logic [data_width-1:0]   operand_b;
  } alu_req_t;

  typedef struct packed {
    logic [data_width-1:0]   result;
    vxsat_t                  vxsat;
  } alu_resp_t;

endpackage

//--- source/simd_arith_unit.sv
`timescale 1ns/10ps

module simd_arith_unit (
  input  simd_alu_pkg::alu_op_e    op_i,
  input  simd_alu_pkg::vew_e       vew_i,
  input  simd_alu_pkg::vxrm_e      vxrm_i,
  input  simd_alu_pkg::lane_word_u opa_i,
  input  simd_alu_pkg::lane_word_u opb_i,
  output simd_alu_pkg::lane_word_u result_o,
  output simd_alu_pkg::vxsat_t     vxsat_o
);

  import simd_alu_pkg::*;

  // One element of width w, returns {sat, result}
  // Operands are widened to 66 bits so every true result is exact
  function automatic logic [64:0] arith_elem(
    input alu_op_e     op,
    input vxrm_e       rm,
    input logic [63:0] a,
    input logic [63:0] b,
    input int unsigned w
  );
    logic        sgn;
    logic        r;
    logic        sat;
    logic [65:0] mask;
    logic [65:0] smax;
    logic [65:0] smin;
    logic [65:0] ea;
    logic [65:0] eb;
    logic [65:0] sum;
    logic [65:0] dif;
    logic [65:0] sel;
    logic [65:0] res;

    sgn  = op inside {VSADD, VSSUB, VAADD};
    mask = (66'd1 << w) - 66'd1;
    smax = mask >> 1;
    smin = ~smax;
    ea   = {2'b00, a} & mask;
    eb   = {2'b00, b} & mask;
    if (sgn && a[w-1]) begin
      ea = ea | ~mask;
    end
    if (sgn && b[w-1]) begin
      eb = eb | ~mask;
    end
    sum = ea + eb;
    dif = eb - ea;
    sel = (op inside {VSSUBU, VSSUB}) ? dif : sum;

    unique case (rm)
      RNU: r = sum[0];
      RNE: r = sum[1] & sum[0];
      RDN: r = 1'b0;
      ROD: r = ~sum[1] & sum[0];
    endcase

    sat = 1'b0;
    unique case (op)
      VADD:  res = sum;
      VSUB:  res = dif;
      VRSUB: res = ea - eb;
      VSADDU: begin
        sat = sum > mask;
        res = sat ? mask : sum;
      end
      VSSUBU: begin
        // Borrow shows as a negative difference
        sat = dif[65];
        res = sat ? '0 : dif;
      end
      VSADD, VSSUB: begin
        sat = ($signed(sel) > $signed(smax)) || ($signed(sel) < $signed(smin));
        res = sat ? (sel[65] ? smin : smax) : sel;
      end
      VAADDU, VAADD: res = {sum[65], sum[65:1]} + 66'(r);
      default: res = '0;
    endcase

    return {sat, res[63:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Lane loop
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic [64:0] elem;

    result_o = '0;
    vxsat_o  = '0;
    unique case (vew_i)
      EW8: for (int e = 0; e < 8; e++) begin
        elem            = arith_elem(op_i, vxrm_i, 64'(opa_i.w8[e]), 64'(opb_i.w8[e]), 8);
        result_o.w8[e]  = elem[7:0];
        vxsat_o[e]      = elem[64];
      end
      EW16: for (int e = 0; e < 4; e++) begin
        elem             = arith_elem(op_i, vxrm_i, 64'(opa_i.w16[e]), 64'(opb_i.w16[e]), 16);
        result_o.w16[e]  = elem[15:0];
        vxsat_o[2*e +: 2] = {2{elem[64]}};
      end
      EW32: for (int e = 0; e < 2; e++) begin
        elem             = arith_elem(op_i, vxrm_i, 64'(opa_i.w32[e]), 64'(opb_i.w32[e]), 32);
        result_o.w32[e]  = elem[31:0];
        vxsat_o[4*e +: 4] = {4{elem[64]}};
      end
      EW64: begin
        elem            = arith_elem(op_i, vxrm_i, opa_i.w64[0], opb_i.w64[0], 64);
        result_o.w64[0] = elem[63:0];
        vxsat_o         = {8{elem[64]}};
      end
    endcase
  end

endmodule

//--- source/simd_compare_unit.sv
`timescale 1ns/10ps

module simd_compare_unit (
  input  simd_alu_pkg::alu_op_e    op_i,
  input  simd_alu_pkg::vew_e       vew_i,
  input  simd_alu_pkg::lane_word_u opa_i,
  input  simd_alu_pkg::lane_word_u opb_i,
  output simd_alu_pkg::lane_word_u result_o
);

  import simd_alu_pkg::*;

  // Compare or min/max on one element of width w
  function automatic logic [63:0] cmp_elem(
    input alu_op_e     op,
    input logic [63:0] a,
    input logic [63:0] b,
    input int unsigned w
  );
    logic        sgn;
    logic        less;
    logic        equal;
    logic [64:0] ea;
    logic [64:0] eb;
    logic [63:0] res;

    sgn = op inside {VMIN, VMAX, VMSLT, VMSLE, VMSGT};
    ea  = {1'b0, a};
    eb  = {1'b0, b};
    if (sgn && a[w-1]) begin
      ea = ea | ({65{1'b1}} << w);
    end
    if (sgn && b[w-1]) begin
      eb = eb | ({65{1'b1}} << w);
    end

    // less means b < a
    less  = $signed(eb) < $signed(ea);
    equal = a == b;

    unique case (op)
      VMINU, VMIN:    res = less ? b : a;
      VMAXU, VMAX:    res = less ? a : b;
      VMSEQ:          res = 64'(equal);
      VMSNE:          res = 64'(!equal);
      VMSLTU, VMSLT:  res = 64'(less);
      VMSLEU, VMSLE:  res = 64'(less | equal);
      VMSGTU, VMSGT:  res = 64'(!(less | equal));
      default:        res = '0;
    endcase
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Lane loop
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    unique case (vew_i)
      EW8: for (int e = 0; e < 8; e++) begin
        result_o.w8[e] = 8'(cmp_elem(op_i, 64'(opa_i.w8[e]), 64'(opb_i.w8[e]), 8));
      end
      EW16: for (int e = 0; e < 4; e++) begin
        result_o.w16[e] = 16'(cmp_elem(op_i, 64'(opa_i.w16[e]), 64'(opb_i.w16[e]), 16));
      end
      EW32: for (int e = 0; e < 2; e++) begin
        result_o.w32[e] = 32'(cmp_elem(op_i, 64'(opa_i.w32[e]), 64'(opb_i.w32[e]), 32));
      end
      EW64: begin
        result_o.w64[0] = cmp_elem(op_i, opa_i.w64[0], opb_i.w64[0], 64);
      end
    endcase
  end

endmodule

//--- source/simd_shift_unit.sv
`timescale 1ns/10ps

module simd_shift_unit (
  input  simd_alu_pkg::alu_op_e    op_i,
  input  simd_alu_pkg::vew_e       vew_i,
  input  simd_alu_pkg::lane_word_u opa_i,
  input  simd_alu_pkg::lane_word_u opb_i,
  output simd_alu_pkg::lane_word_u result_o
);

  import simd_alu_pkg::*;

  // Shift b by the low log2(w) bits of a
  function automatic logic [63:0] shift_elem(
    input alu_op_e     op,
    input logic [63:0] a,
    input logic [63:0] b,
    input int unsigned w
  );
    logic [5:0]  amt;
    logic [63:0] eb;
    logic [63:0] res;

    amt = a[5:0] & 6'(w - 1);
    eb  = b;
    if (b[w-1]) begin
      eb = eb | ({64{1'b1}} << w);
    end

    unique case (op)
      VSLL:    res = b << amt;
      VSRL:    res = b >> amt;
      VSRA:    res = $signed(eb) >>> amt;
      default: res = '0;
    endcase
    return res;
  endfunction

  always_comb begin
    result_o = '0;
    unique case (vew_i)
      EW8: for (int e = 0; e < 8; e++) begin
        result_o.w8[e] = 8'(shift_elem(op_i, 64'(opa_i.w8[e]), 64'(opb_i.w8[e]), 8));
      end
      EW16: for (int e = 0; e < 4; e++) begin
        result_o.w16[e] = 16'(shift_elem(op_i, 64'(opa_i.w16[e]), 64'(opb_i.w16[e]), 16));
      end
      EW32: for (int e = 0; e < 2; e++) begin
        result_o.w32[e] = 32'(shift_elem(op_i, 64'(opa_i.w32[e]), 64'(opb_i.w32[e]), 32));
      end
      EW64: begin
        result_o.w64[0] = shift_elem(op_i, opa_i.w64[0], opb_i.w64[0], 64);
      end
    endcase
  end

endmodule
